// ==== bench/tb_uart_debug.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_dbg_settings.svh"

module tb_uart_debug import uart_dbg_pkg::*;;

	// one serial bit is 16 ticks of 27 clocks
	localparam int BIT_CYC = `OVERSAMPLE * `TICK_DIV;
	localparam int FRAME_CYC = 10 * BIT_CYC;
	localparam int START_TIMEOUT = 3 * FRAME_CYC;

	logic                clk;
	logic                i_rst_n;
	logic                i_rx;
	logic [`PC_BITS-1:0] i_mips_pc;
	logic                o_tx;
	logic [3:0]          o_leds;

	int          errors;
	int          tests;
	int          cmd_count;
	logic [31:0] rng;

	uart_debug_top uart_debug_top_i (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_rx      (i_rx),
		.i_mips_pc (i_mips_pc),
		.o_tx      (o_tx),
		.o_leds    (o_leds)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("** Error @%0t ns: %s expected %0h got %0h", $time, sig, exp, got);
			errors++;
		end
	endtask

	// start, 8 data bits lsb first, stop; each bit one full period
	task automatic send_byte(input logic [7:0] data, input logic stop);
		logic [9:0] frame;
		int         i;
		frame = {stop, data, 1'b0};
		for (i = 0; i < 10; i++) begin
			i_rx = frame[i];
			repeat (BIT_CYC) begin
				@(posedge clk);
				#1;
			end
		end
		i_rx = 1'b1;
	endtask

	// o_tx sampled mid bit on falling edges
	task automatic recv_byte(output logic [7:0] data);
		int n;
		int i;
		data = 8'hxx;
		n = 0;
		while (o_tx !== 1'b0 && n < START_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (o_tx !== 1'b0) begin
			$display("timeout: no start bit on o_tx within %0d cycles", START_TIMEOUT);
			errors++;
			return;
		end
		// middle of the start bit, then middle of each later bit
		repeat (BIT_CYC / 2) @(negedge clk);
		check_value("o_tx start bit", 32'd0, 32'(o_tx));
		for (i = 0; i < 8; i++) begin
			repeat (BIT_CYC) @(negedge clk);
			data[i] = o_tx;
		end
		repeat (BIT_CYC) @(negedge clk);
		check_value("o_tx stop bit", 32'd1, 32'(o_tx));
	endtask

	task automatic expect_silence(input int cycles, input string what);
		logic quiet;
		int   n;
		quiet = 1'b1;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (o_tx !== 1'b1) quiet = 1'b0;
		end
		assert (quiet) else begin
			$display("o_tx left idle %s, but no reply was expected", what);
			errors++;
		end
		// back to the drive point just after a rising edge
		@(posedge clk);
		#1;
	endtask

	// command out while the reply is collected; reply bytes packed msb first
	task automatic exchange(input logic [7:0] cmd, input int n, output logic [31:0] rsp);
		logic [7:0] b;
		int         i;
		rsp = '0;
		fork
			send_byte(cmd, 1'b1);
			begin
				for (i = 0; i < n; i++) begin
					recv_byte(b);
					rsp = {rsp[23:0], b};
				end
			end
		join
		@(posedge clk);
		#1;
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		$display("%s: %s", name, (errors == err_before) ? "ok" : "FAILED");
	endtask

	task automatic check_count(input string name);
		logic [31:0] rsp;
		cmd_count++;
		exchange(`CMD_COUNT, 1, rsp);
		check_value(name, 32'(cmd_count % 256), rsp);
	endtask

	task automatic test_reset();
		int e;
		e = errors;
		check_value("o_tx", 32'd1, 32'(o_tx));
		check_value("o_leds", 32'(IDLE), 32'(o_leds));
		finish_test("reset idle", e);
	endtask

	task automatic test_pc_read();
		logic [31:0] rsp;
		int          k;
		int          e;
		e = errors;
		for (k = 0; k < 3; k++) begin
			rng = xorshift32(rng);
			i_mips_pc = rng;
			cmd_count++;
			exchange(`CMD_PC, 4, rsp);
			check_value("pc reply", rng, rsp);
			// a fifth byte would be an error
			expect_silence(FRAME_CYC, "after the fourth pc byte");
		end
		finish_test("pc read", e);
	endtask

	task automatic test_count();
		int e;
		e = errors;
		check_count("count reply");
		finish_test("command count", e);
	endtask

	task automatic test_unknown();
		logic [31:0] rsp;
		logic [7:0]  b;
		int          k;
		int          e;
		e = errors;
		for (k = 0; k < 4; k++) begin
			do begin
				rng = xorshift32(rng);
				b = rng[7:0];
			end while (b == `CMD_PC || b == `CMD_COUNT);
			exchange(b, 1, rsp);
			check_value("unknown reply", 32'(`RSP_UNKNOWN), rsp);
		end
		check_count("count after unknown");
		finish_test("unknown commands", e);
	endtask

	// a pc command with a low stop bit must vanish
	task automatic test_framing_error();
		int e;
		e = errors;
		fork
			send_byte(`CMD_PC, 1'b0);
			expect_silence(2 * FRAME_CYC, "after a bad stop bit");
		join
		@(posedge clk);
		#1;
		check_count("count after framing error");
		finish_test("framing error", e);
	endtask

	initial begin
		errors = 0;
		tests = 0;
		cmd_count = 0;
		rng = 32'd92068;
		i_rst_n = 1'b0;
		i_rx = 1'b1;
		i_mips_pc = '0;
		repeat (3) @(posedge clk);
		#1;
		i_rst_n = 1'b1;
		test_reset();
		test_pc_read();
		test_count();
		test_unknown();
		test_framing_error();
		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the UART debug port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_uart_debug \
	--Mdir obj_dir -o tb_uart_debug
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

output=$(./obj_dir/tb_uart_debug)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

// ==== sim.f ====
+incdir+src
src/uart_dbg_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/debug_unit.sv
src/uart_debug_top.sv
bench/tb_uart_debug.sv

// ==== src/baud_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_dbg_settings.svh"

module baud_tick_gen (
	input  logic clk,
	input  logic i_rst_n,
	output logic o_tick
);

	localparam int TICK_DIV = `TICK_DIV;
	localparam int CW = $clog2(TICK_DIV);
	localparam logic [CW-1:0] CNT_LAST = CW'(TICK_DIV - 1);

	logic [CW-1:0] cnt;

	// free running divider, wraps every TICK_DIV cycles
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= '0;
		end else if (cnt == CNT_LAST) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// one cycle strobe on the wrap
	assign o_tick = (cnt == CNT_LAST);

endmodule

`default_nettype wire

// ==== src/debug_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_dbg_settings.svh"

module debug_unit import uart_dbg_pkg::*; (
	input  logic                  clk,
	input  logic                  i_rst_n,
	input  logic                  i_rx_valid,
	input  logic [`DATA_BITS-1:0] i_rx_data,
	input  logic [`PC_BITS-1:0]   i_mips_pc,
	input  logic                  i_tx_ack,
	output tx_req_t               o_tx_req,
	output dbg_state_t            o_state
);

	localparam int NBYTES = `PC_BITS / `DATA_BITS;
	localparam int LCW = $clog2(NBYTES);

	dbg_state_t            state;
	logic [`DATA_BITS-1:0] cmd_q;
	logic [`DATA_BITS-1:0] cmd_cnt;
	logic [`PC_BITS-1:0]   pc_sr;
	logic [LCW-1:0]        bytes_left;
	logic                  accept;
	logic                  is_cmd;

	// new bytes only matter while idle
	assign accept = (state == IDLE) && i_rx_valid;
	assign is_cmd = (i_rx_data == `CMD_PC) || (i_rx_data == `CMD_COUNT);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= IDLE;
			cmd_cnt    <= '0;
			bytes_left <= '0;
			o_tx_req   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						// count wraps at 256
						if (is_cmd) begin
							cmd_cnt <= cmd_cnt + 1'b1;
						end
						state <= DECODE;
					end
				end
				DECODE: begin
					// first reply byte goes out straight from here
					o_tx_req.req <= 1'b1;
					state        <= WAIT_ACK;
					case (cmd_q)
						`CMD_PC: begin
							o_tx_req.data <= pc_sr[`PC_BITS-1 -: `DATA_BITS];
							bytes_left    <= LCW'(NBYTES - 1);
						end
						`CMD_COUNT: begin
							o_tx_req.data <= cmd_cnt;
							bytes_left    <= '0;
						end
						default: begin
							o_tx_req.data <= `RSP_UNKNOWN;
							bytes_left    <= '0;
						end
					endcase
				end
				// later pc bytes, msb first
				SEND: begin
					o_tx_req.req  <= 1'b1;
					o_tx_req.data <= pc_sr[`PC_BITS-1 -: `DATA_BITS];
					state         <= WAIT_ACK;
				end
				WAIT_ACK: begin
					// hold req and data until the frame is out
					if (i_tx_ack) begin
						o_tx_req.req <= 1'b0;
						state        <= WAIT_RELEASE;
					end
				end
				WAIT_RELEASE: begin
					if (!i_tx_ack) begin
						if (bytes_left == '0) begin
							state <= IDLE;
						end else begin
							bytes_left <= bytes_left - 1'b1;
							state      <= SEND;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// pc snapshot taken with the command byte
	// shifted a byte at a time as the reply is sent
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= i_rx_data;
			pc_sr <= i_mips_pc;
		end else if ((state == DECODE) || (state == SEND)) begin
			pc_sr <= pc_sr << `DATA_BITS;
		end
	end

	assign o_state = state;

endmodule

`default_nettype wire

// ==== src/uart_dbg_pkg.sv ====
`default_nettype none

`include "uart_dbg_settings.svh"

package uart_dbg_pkg;

	// debug unit states, also shown on the leds
	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		DECODE       = 4'd1,
		SEND         = 4'd2,
		WAIT_ACK     = 4'd3,
		WAIT_RELEASE = 4'd4
	} dbg_state_t;

	// request side of the req/ack link to the transmitter
	// data must stay stable while req is high
	typedef struct packed {
		logic                  req;
		logic [`DATA_BITS-1:0] data;
	} tx_req_t;

endpackage

`default_nettype wire

// ==== src/uart_dbg_settings.svh ====
`ifndef UART_DBG_SETTINGS_SVH
`define UART_DBG_SETTINGS_SVH

// serial frame and datapath widths
`define DATA_BITS 8
`define PC_BITS 32

// clock and line rate
`define CLK_FREQ_HZ 50000000
`define BAUD_RATE 115200
`define OVERSAMPLE 16
// clock cycles per oversampling tick, 27 at these rates
`define TICK_DIV (`CLK_FREQ_HZ / (`BAUD_RATE * `OVERSAMPLE))

// host command bytes and the fallback reply
`define CMD_PC 8'h70
`define CMD_COUNT 8'h63
`define RSP_UNKNOWN 8'h3F

`endif

// ==== src/uart_debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_dbg_settings.svh"

module uart_debug_top import uart_dbg_pkg::*; (
	input  logic                clk,
	input  logic                i_rst_n,
	input  logic                i_rx,
	input  logic [`PC_BITS-1:0] i_mips_pc,
	output logic                o_tx,
	output logic [3:0]          o_leds
);

	logic                  tick;
	logic                  rx_valid;
	logic [`DATA_BITS-1:0] rx_data;
	tx_req_t               tx_req;
	logic                  tx_ack;

	// shared 16x tick for both directions
	baud_tick_gen baud_tick_gen_i (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.o_tick  (tick)
	);

	uart_rx uart_rx_i (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_tick     (tick),
		.i_rx       (i_rx),
		.o_rx_valid (rx_valid),
		.o_rx_data  (rx_data)
	);

	// state goes straight out to the leds
	debug_unit debug_unit_i (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_rx_valid (rx_valid),
		.i_rx_data  (rx_data),
		.i_mips_pc  (i_mips_pc),
		.i_tx_ack   (tx_ack),
		.o_tx_req   (tx_req),
		.o_state    (o_leds)
	);

	uart_tx uart_tx_i (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_tick   (tick),
		.i_tx_req (tx_req),
		.o_tx_ack (tx_ack),
		.o_tx     (o_tx)
	);

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_dbg_settings.svh"

module uart_rx (
	input  logic                  clk,
	input  logic                  i_rst_n,
	input  logic                  i_tick,
	input  logic                  i_rx,
	output logic                  o_rx_valid,
	output logic [`DATA_BITS-1:0] o_rx_data
);

	localparam int TCW = $clog2(`OVERSAMPLE);
	localparam int BCW = $clog2(`DATA_BITS);
	localparam logic [TCW-1:0] TICK_MID = TCW'(`OVERSAMPLE / 2 - 1);
	localparam logic [TCW-1:0] TICK_LAST = TCW'(`OVERSAMPLE - 1);
	localparam logic [BCW-1:0] BIT_LAST = BCW'(`DATA_BITS - 1);

	// receiver states
	localparam logic [1:0] RX_IDLE = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA = 2'd2;
	localparam logic [1:0] RX_STOP = 2'd3;

	logic                  rx_meta;
	logic                  rx_sync;
	logic                  rx_prev;
	logic [1:0]            state;
	logic [TCW-1:0]        tick_cnt;
	logic [BCW-1:0]        bit_cnt;
	logic [`DATA_BITS-1:0] rx_shift;
	logic                  sample_bit;

	// two flop synchronizer, line idles high
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// a data bit is taken in its middle
	assign sample_bit = (state == RX_DATA) && i_tick && (tick_cnt == TICK_LAST);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= RX_IDLE;
			tick_cnt   <= '0;
			bit_cnt    <= '0;
			o_rx_valid <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					// falling edge on the line
					if (rx_prev && !rx_sync) begin
						state    <= RX_START;
						tick_cnt <= '0;
					end
				end
				RX_START: begin
					if (i_tick) begin
						if (tick_cnt == TICK_MID) begin
							// still low at midpoint, so a real start bit
							state    <= rx_sync ? RX_IDLE : RX_DATA;
							tick_cnt <= '0;
							bit_cnt  <= '0;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				RX_DATA: begin
					if (i_tick) begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == TICK_LAST) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == BIT_LAST) begin
								state <= RX_STOP;
							end
						end
					end
				end
				RX_STOP: begin
					if (i_tick) begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == TICK_LAST) begin
							// framing error drops the byte silently
							o_rx_valid <= rx_sync;
							state      <= RX_IDLE;
						end
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge clk) begin
		if (sample_bit) begin
			rx_shift <= {rx_sync, rx_shift[`DATA_BITS-1:1]};
		end
	end

	assign o_rx_data = rx_shift;

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_dbg_settings.svh"

module uart_tx import uart_dbg_pkg::*; (
	input  logic    clk,
	input  logic    i_rst_n,
	input  logic    i_tick,
	input  tx_req_t i_tx_req,
	output logic    o_tx_ack,
	output logic    o_tx
);

	localparam int TCW = $clog2(`OVERSAMPLE);
	localparam int BCW = $clog2(`DATA_BITS);
	localparam logic [TCW-1:0] TICK_LAST = TCW'(`OVERSAMPLE - 1);
	localparam logic [BCW-1:0] BIT_LAST = BCW'(`DATA_BITS - 1);

	// transmitter states
	localparam logic [2:0] TX_IDLE = 3'd0;
	localparam logic [2:0] TX_START = 3'd1;
	localparam logic [2:0] TX_DATA = 3'd2;
	localparam logic [2:0] TX_STOP = 3'd3;
	localparam logic [2:0] TX_ACK = 3'd4;
	localparam logic [2:0] TX_RELEASE = 3'd5;

	logic [2:0]            state;
	logic [TCW-1:0]        tick_cnt;
	logic [BCW-1:0]        bit_cnt;
	logic [`DATA_BITS-1:0] tx_shift;
	logic                  bit_end;
	logic                  launch;

	// frame starts on the first tick with req high
	assign launch = (state == TX_IDLE) && i_tx_req.req && i_tick;
	// last tick of the current bit period
	assign bit_end = i_tick && (tick_cnt == TICK_LAST);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			if (i_tick) begin
				tick_cnt <= tick_cnt + 1'b1;
			end
			case (state)
				TX_IDLE: begin
					tick_cnt <= '0;
					if (launch) begin
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state   <= TX_DATA;
						bit_cnt <= '0;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_LAST) begin
							state <= TX_STOP;
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state <= TX_ACK;
					end
				end
				// ack held until the requester lets go
				TX_ACK: begin
					if (!i_tx_req.req) begin
						state <= TX_RELEASE;
					end
				end
				// ack low for a cycle before idle
				TX_RELEASE: state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	// byte latched at launch, lsb first out
	always_ff @(posedge clk) begin
		if (launch) begin
			tx_shift <= i_tx_req.data;
		end else if ((state == TX_DATA) && bit_end) begin
			tx_shift <= tx_shift >> 1;
		end
	end

	always_comb begin
		case (state)
			TX_START: o_tx = 1'b0;
			TX_DATA:  o_tx = tx_shift[0];
			default:  o_tx = 1'b1;
		endcase
	end

	assign o_tx_ack = (state == TX_ACK);

endmodule

`default_nettype wire
